// File: verilog/spi_apb_defines.svh
`ifndef SPI_APB_DEFINES_SVH
`define SPI_APB_DEFINES_SVH

////////////////////
// Bus widths

`define SPI_APB_ADDR_W		9
`define SPI_APB_DATA_W		32

////////////////////
// Sizing and reset values

// SCK half-period in apb cycles after reset
`define SPI_CLKDIV_RESET	50
`define SPI_BURST_MAX		256
`define SPI_BUF_WORDS		64

////////////////////
// Register offsets, writable ones on 0x20 boundaries

`define SPI_REG_CLK_DIV		9'h000
`define SPI_REG_DATA		9'h020
`define SPI_REG_CS_N		9'h040
`define SPI_REG_STATUS		9'h060
`define SPI_REG_STATUS_2	9'h080
`define SPI_REG_BURST_RDLEN	9'h0a0
`define SPI_REG_QUAD_CAP	9'h0c0
// Receive buffer occupies everything from here up
`define SPI_REG_RXBUF		9'h100

`endif

// File: verilog/spi_apb_pkg.sv
`include "spi_apb_defines.svh"

package spi_apb_pkg;

	////////////////////
	// APB bus

	// Requester side, driven by the bus master
	typedef struct packed {
		logic [`SPI_APB_ADDR_W-1:0]	paddr;
		logic						psel;
		logic						penable;
		logic						pwrite;
		logic [`SPI_APB_DATA_W-1:0]	pwdata;
	} apb_req_t;

	// Completer side
	typedef struct packed {
		logic [`SPI_APB_DATA_W-1:0]	prdata;
		logic						pready;
		logic						pslverr;
	} apb_rsp_t;

	////////////////////
	// Internal transfers

	// Register block to sequencer
	typedef struct packed {
		// Set for a burst read, clear for one byte
		logic						burst;
		// Byte to send in single mode
		logic [7:0]					tx_byte;
		// Burst length in bytes, ignored in single mode
		logic [8:0]					len;
	} spi_cmd_t;

	// Sequencer to receive buffer
	typedef struct packed {
		logic [7:0]					data;
		// Position of the byte within its burst
		logic [7:0]					index;
	} spi_byte_t;

endpackage

// File: verilog/spi_sck_timer.sv
`timescale 1ns/1ps

module spi_sck_timer (
	input  logic		apb,
	input  logic		reset,
	input  logic [15:0]	clk_div,
	input  logic		run,
	output logic		half_tick
);

	////////////////////
	// Half-period counter

	// Divider captured between bytes
	logic [15:0]	period;
	// Cycles left in the current half-period
	logic [15:0]	count;

	always_ff @(posedge apb) begin
		if (reset) begin
			period		<= 16'd1;
			count		<= '0;
			half_tick	<= 1'b0;
		end else if (!run) begin
			// Idle so reload from the live divider
			period		<= clk_div;
			count		<= clk_div - 16'd1;
			half_tick	<= 1'b0;
		end else if (count == 16'd0) begin
			// Strobe on expiry and start the next half-period
			count		<= period - 16'd1;
			half_tick	<= 1'b1;
		end else begin
			count		<= count - 16'd1;
			half_tick	<= 1'b0;
		end
	end

	////////////////////
	// Checks

	// Run drops only on the final strobe and never cuts a half-period short
	assert property (@(posedge apb) disable iff (reset)
		$fell(run) |-> half_tick);

endmodule

// File: verilog/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter (
	input  logic		apb,
	input  logic		reset,
	input  logic		byte_valid,
	output logic		byte_ready,
	input  logic [7:0]	tx_byte,
	input  logic		half_tick,
	output logic		run,
	output logic		rx_valid,
	output logic [7:0]	rx_data,
	output logic		spi_sck,
	output logic		spi_mosi,
	input  logic		spi_miso
);

	logic		busy;
	logic		sck;
	logic [3:0]	edge_cnt;
	logic [7:0]	tx_sr;
	logic [7:0]	rx_sr;
	logic		accept;
	logic		fall;
	logic		last_edge;

	assign byte_ready	= !busy;
	assign accept		= byte_valid && byte_ready;
	// A strobe while SCK is high is a falling edge
	assign fall			= busy && half_tick && sck;
	// Sixteenth strobe ends the byte
	assign last_edge	= busy && half_tick && (edge_cnt == 4'd15);
	// Stop the timer on the final strobe itself
	assign run			= busy && !last_edge;

	assign spi_sck		= sck;
	// MSB first
	assign spi_mosi		= tx_sr[7];

	////////////////////
	// Control

	always_ff @(posedge apb) begin
		if (reset) begin
			busy		<= 1'b0;
			sck			<= 1'b0;
			edge_cnt	<= '0;
			rx_valid	<= 1'b0;
			tx_sr		<= '0;
		end else begin
			rx_valid	<= 1'b0;
			if (accept) begin
				busy		<= 1'b1;
				sck			<= 1'b0;
				edge_cnt	<= '0;
				tx_sr		<= tx_byte;
			end else if (busy && half_tick) begin
				sck			<= !sck;
				edge_cnt	<= edge_cnt + 4'd1;
				// Next MOSI bit goes out after the device sampled on the rising edge
				if (fall)
					tx_sr	<= {tx_sr[6:0], 1'b0};
				if (last_edge) begin
					busy		<= 1'b0;
					rx_valid	<= 1'b1;
				end
			end
		end
	end

	////////////////////
	// Receive path

	// Inverted local sampling captures MISO on our falling edge
	always_ff @(posedge apb) begin
		if (fall)
			rx_sr	<= {rx_sr[6:0], spi_miso};
		if (last_edge)
			rx_data	<= {rx_sr[6:0], spi_miso};
	end

	////////////////////
	// Checks

	// A new byte starts with SCK low and the strobe count wrapped to zero
	assert property (@(posedge apb) disable iff (reset)
		accept |-> !sck && (edge_cnt == 4'd0));

endmodule

// File: verilog/spi_burst_sequencer.sv
`timescale 1ns/1ps
`include "spi_apb_defines.svh"

module spi_burst_sequencer (
	input  logic					apb,
	input  logic					reset,
	input  spi_apb_pkg::spi_cmd_t	cmd,
	input  logic					cmd_valid,
	output logic					cmd_ready,
	output logic					byte_valid,
	input  logic					byte_ready,
	output logic [7:0]				tx_byte,
	input  logic					rx_valid,
	input  logic [7:0]				rx_data,
	output spi_apb_pkg::spi_byte_t	wr_byte,
	output logic					wr_valid,
	output logic					wr_last,
	output logic					busy,
	output logic [7:0]				last_rx
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT,
		S_FLUSH
	} state_t;

	state_t		state;
	// Bytes still to shift in the current command
	logic [8:0]	remaining;
	logic [7:0]	idx;
	logic		is_burst;
	logic [7:0]	tx_hold;
	logic		final_byte;

	assign cmd_ready	= (state == S_IDLE);
	assign busy			= (state != S_IDLE);
	assign byte_valid	= (state == S_ISSUE);
	assign tx_byte		= tx_hold;
	assign final_byte	= (remaining == 9'd1);

	////////////////////
	// FSM

	always_ff @(posedge apb) begin
		if (reset) begin
			state		<= S_IDLE;
			remaining	<= '0;
			idx			<= '0;
			is_burst	<= 1'b0;
			tx_hold		<= '0;
			wr_valid	<= 1'b0;
			wr_last		<= 1'b0;
		end else begin
			wr_valid	<= 1'b0;
			wr_last		<= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmd_valid) begin
						is_burst	<= cmd.burst;
						idx			<= '0;
						if (cmd.burst) begin
							// Burst clocks out zeros
							tx_hold		<= 8'h00;
							remaining	<= (cmd.len > 9'(`SPI_BURST_MAX)) ?
								9'(`SPI_BURST_MAX) : cmd.len;
							// Zero length issues nothing
							if (cmd.len != 9'd0)
								state	<= S_ISSUE;
						end else begin
							tx_hold		<= cmd.tx_byte;
							remaining	<= 9'd1;
							state		<= S_ISSUE;
						end
					end
				end
				S_ISSUE: begin
					if (byte_ready)
						state	<= S_WAIT;
				end
				S_WAIT: begin
					if (rx_valid) begin
						remaining	<= remaining - 9'd1;
						if (is_burst) begin
							wr_valid	<= 1'b1;
							wr_last		<= final_byte;
							idx			<= idx + 8'd1;
							state		<= final_byte ? S_FLUSH : S_ISSUE;
						end else begin
							state	<= S_IDLE;
						end
					end
				end
				// Buffer commits the last word here
				S_FLUSH: state	<= S_IDLE;
				default: state	<= S_IDLE;
			endcase
		end
	end

	////////////////////
	// Received data

	always_ff @(posedge apb) begin
		if (rx_valid) begin
			last_rx			<= rx_data;
			wr_byte.data	<= rx_data;
			wr_byte.index	<= idx;
		end
	end

	// Bytes done and bytes left never exceed the clamped burst
	assert property (@(posedge apb) disable iff (reset)
		(state == S_ISSUE || state == S_WAIT) |->
			(remaining != 9'd0) &&
			(({1'b0, idx} + remaining) <= 9'(`SPI_BURST_MAX)));

endmodule

// File: verilog/spi_burst_buffer.sv
`timescale 1ns/1ps
`include "spi_apb_defines.svh"

module spi_burst_buffer (
	input  logic					apb,
	input  logic					reset,
	input  spi_apb_pkg::spi_byte_t	wr_byte,
	input  logic					wr_valid,
	input  logic					wr_last,
	input  logic [5:0]				rd_addr,
	output logic [31:0]				rd_data
);

	logic [31:0]	ram [`SPI_BUF_WORDS];
	// Lanes 0 to 2 of the word being built
	logic [23:0]	partial;
	logic [31:0]	wr_word;
	logic [1:0]		lane;
	// Bytes seen so far in this burst
	logic [8:0]		burst_bytes;

	assign lane	= wr_byte.index[1:0];

	// Merge new byte, lanes above it stay zero
	always_comb begin
		case (lane)
			2'd0:		wr_word	= {24'h0, wr_byte.data};
			2'd1:		wr_word	= {16'h0, wr_byte.data, partial[7:0]};
			2'd2:		wr_word	= {8'h0, wr_byte.data, partial[15:0]};
			default:	wr_word	= {wr_byte.data, partial};
		endcase
	end

	////////////////////
	// Write side

	always_ff @(posedge apb) begin
		if (wr_valid) begin
			partial	<= wr_word[23:0];
			// Full word, or a short tail at the end of the burst
			if (lane == 2'd3 || wr_last)
				ram[wr_byte.index[7:2]]	<= wr_word;
		end
	end

	// Position tracking, restarts after each burst
	always_ff @(posedge apb) begin
		if (reset)
			burst_bytes	<= '0;
		else if (wr_valid)
			burst_bytes	<= wr_last ? 9'd0 : burst_bytes + 9'd1;
	end

	// Little-endian word per address, no read latency
	assign rd_data	= ram[rd_addr];

	// Bytes arrive in order and a burst never runs past the buffer
	assert property (@(posedge apb) disable iff (reset)
		wr_valid |-> (burst_bytes < 9'(`SPI_BURST_MAX)) &&
			(wr_byte.index == burst_bytes[7:0]));

endmodule

// File: verilog/spi_apb_regs.sv
`timescale 1ns/1ps
`include "spi_apb_defines.svh"

module spi_apb_regs (
	input  logic					apb,
	input  logic					reset,
	input  spi_apb_pkg::apb_req_t	apb_req,
	output spi_apb_pkg::apb_rsp_t	apb_rsp,
	output spi_apb_pkg::spi_cmd_t	cmd,
	output logic					cmd_valid,
	input  logic					cmd_ready,
	input  logic					busy,
	input  logic [7:0]				last_rx,
	output logic [5:0]				rd_addr,
	input  logic [31:0]				rd_data,
	output logic [15:0]				clk_div,
	output logic					spi_cs_n
);

	logic [8:0]		addr;
	logic			access;
	logic			is_cmd_wr;
	logic			rd_err;
	logic			wr_err;
	logic [31:0]	rdata;
	logic [8:0]		burst_len;

	assign addr		= apb_req.paddr;
	// Access phase
	assign access	= apb_req.psel && apb_req.penable;

	////////////////////
	// Command issue

	assign is_cmd_wr	= access && apb_req.pwrite &&
		(addr == `SPI_REG_DATA || addr == `SPI_REG_BURST_RDLEN);
	// Anything past 9 bits saturates, the sequencer clamps further
	assign burst_len	= (|apb_req.pwdata[31:9]) ? 9'h1ff : apb_req.pwdata[8:0];

	assign cmd_valid	= is_cmd_wr;
	assign cmd.burst	= (addr == `SPI_REG_BURST_RDLEN);
	assign cmd.tx_byte	= apb_req.pwdata[7:0];
	assign cmd.len		= burst_len;

	////////////////////
	// Read mux and decode

	// Word index within the receive buffer window
	assign rd_addr	= addr[7:2];

	always_comb begin
		rdata	= '0;
		rd_err	= 1'b0;
		if (addr >= `SPI_REG_RXBUF) begin
			rdata	= rd_data;
		end else begin
			case (addr)
				`SPI_REG_CLK_DIV:	rdata	= {16'h0, clk_div};
				`SPI_REG_DATA:		rdata	= {24'h0, last_rx};
				`SPI_REG_CS_N:		rdata	= {31'h0, spi_cs_n};
				`SPI_REG_STATUS,
				`SPI_REG_STATUS_2:	rdata	= {31'h0, busy};
				// Plain SPI only
				`SPI_REG_QUAD_CAP:	rdata	= '0;
				default:			rd_err	= 1'b1;
			endcase
		end
	end

	// Writable registers only
	always_comb begin
		case (addr)
			`SPI_REG_CLK_DIV,
			`SPI_REG_DATA,
			`SPI_REG_CS_N,
			`SPI_REG_BURST_RDLEN:	wr_err	= 1'b0;
			default:				wr_err	= 1'b1;
		endcase
	end

	// Command writes wait for the sequencer, everything else is zero-wait
	assign apb_rsp.pready	= access && (!is_cmd_wr || cmd_ready);
	assign apb_rsp.pslverr	= access && (apb_req.pwrite ? wr_err : rd_err);
	assign apb_rsp.prdata	= rdata;

	////////////////////
	// Configuration registers

	always_ff @(posedge apb) begin
		if (reset) begin
			clk_div		<= 16'(`SPI_CLKDIV_RESET);
			spi_cs_n	<= 1'b1;
		end else if (access && apb_req.pwrite) begin
			case (addr)
				// Zero would stop SCK, store 1 instead
				`SPI_REG_CLK_DIV:
					clk_div	<= (apb_req.pwdata[15:0] == 16'h0) ?
						16'd1 : apb_req.pwdata[15:0];
				`SPI_REG_CS_N:		spi_cs_n	<= apb_req.pwdata[0];
				default: begin
				end
			endcase
		end
	end

	// A stalled command write must be held by the master until accepted
	assert property (@(posedge apb) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

// File: verilog/spi_apb_host.sv
`timescale 1ns/1ps

module spi_apb_host (
	input  logic					apb,
	input  logic					reset,
	input  spi_apb_pkg::apb_req_t	apb_req,
	output spi_apb_pkg::apb_rsp_t	apb_rsp,
	output logic					spi_sck,
	output logic					spi_mosi,
	output logic					spi_cs_n,
	input  logic					spi_miso
);

	////////////////////
	// Interconnect

	// Register block to sequencer
	spi_apb_pkg::spi_cmd_t	cmd;
	logic					cmd_valid;
	logic					cmd_ready;
	logic					busy;
	logic [7:0]				last_rx;
	logic [15:0]			clk_div;

	// Sequencer to shifter
	logic					byte_valid;
	logic					byte_ready;
	logic [7:0]				tx_byte;
	logic					rx_valid;
	logic [7:0]				rx_data;

	// Shifter to timer
	logic					run;
	logic					half_tick;

	// Burst path
	spi_apb_pkg::spi_byte_t	wr_byte;
	logic					wr_valid;
	logic					wr_last;
	logic [5:0]				rd_addr;
	logic [31:0]			rd_data;

	spi_apb_regs spi_apb_regs_inst (
		.apb		(apb),
		.reset		(reset),
		.apb_req	(apb_req),
		.apb_rsp	(apb_rsp),
		.cmd		(cmd),
		.cmd_valid	(cmd_valid),
		.cmd_ready	(cmd_ready),
		.busy		(busy),
		.last_rx	(last_rx),
		.rd_addr	(rd_addr),
		.rd_data	(rd_data),
		.clk_div	(clk_div),
		.spi_cs_n	(spi_cs_n)
	);

	spi_burst_sequencer spi_burst_sequencer_inst (
		.apb		(apb),
		.reset		(reset),
		.cmd		(cmd),
		.cmd_valid	(cmd_valid),
		.cmd_ready	(cmd_ready),
		.byte_valid	(byte_valid),
		.byte_ready	(byte_ready),
		.tx_byte	(tx_byte),
		.rx_valid	(rx_valid),
		.rx_data	(rx_data),
		.wr_byte	(wr_byte),
		.wr_valid	(wr_valid),
		.wr_last	(wr_last),
		.busy		(busy),
		.last_rx	(last_rx)
	);

	spi_shifter spi_shifter_inst (
		.apb		(apb),
		.reset		(reset),
		.byte_valid	(byte_valid),
		.byte_ready	(byte_ready),
		.tx_byte	(tx_byte),
		.half_tick	(half_tick),
		.run		(run),
		.rx_valid	(rx_valid),
		.rx_data	(rx_data),
		.spi_sck	(spi_sck),
		.spi_mosi	(spi_mosi),
		.spi_miso	(spi_miso)
	);

	spi_sck_timer spi_sck_timer_inst (
		.apb		(apb),
		.reset		(reset),
		.clk_div	(clk_div),
		.run		(run),
		.half_tick	(half_tick)
	);

	spi_burst_buffer spi_burst_buffer_inst (
		.apb		(apb),
		.reset		(reset),
		.wr_byte	(wr_byte),
		.wr_valid	(wr_valid),
		.wr_last	(wr_last),
		.rd_addr	(rd_addr),
		.rd_data	(rd_data)
	);

endmodule

// File: sim/spi_loopback_device.sv
`timescale 1ns/1ps

module spi_loopback_device (
	input  logic			spi_sck,
	input  logic			spi_mosi,
	input  logic			spi_cs_n,
	output logic			spi_miso,
	output logic [7:0]		mosi_byte,
	output int unsigned		mosi_count,
	output int unsigned		reply_count
);

	// Bytes returned since chip select fell
	int unsigned	k = 0;
	// Bytes seen on MOSI over the whole run
	int unsigned	total = 0;
	logic [2:0]		fall_bits = 3'd0;
	logic [2:0]		rise_bits = 3'd0;
	logic [7:0]		mosi_sr;
	logic [7:0]		reply;

	assign reply		= 8'hc3 + k[7:0];
	// MSB first, next bit set up after each falling SCK
	assign spi_miso		= reply[3'd7 - fall_bits];
	assign mosi_count	= total;
	assign reply_count	= k;

	////////////////////
	// Receive side

	// Device samples on rising SCK, framing restarts with chip select
	always @(posedge spi_sck or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			rise_bits	<= 3'd0;
		end else begin
			mosi_sr		<= {mosi_sr[6:0], spi_mosi};
			rise_bits	<= rise_bits + 3'd1;
			if (rise_bits == 3'd7) begin
				mosi_byte	<= {mosi_sr[6:0], spi_mosi};
				total		<= total + 1;
			end
		end
	end

	////////////////////
	// Reply side

	// Counting reply, held at the first byte while deselected
	always @(negedge spi_sck or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			k			<= 0;
			fall_bits	<= 3'd0;
		end else begin
			fall_bits	<= fall_bits + 3'd1;
			if (fall_bits == 3'd7)
				k	<= k + 1;
		end
	end

endmodule

// File: sim/spi_apb_host_tb.sv
`timescale 1ns/1ps
`include "spi_apb_defines.svh"

module spi_apb_host_tb;

	localparam int		CLK_PERIOD		= 8;
	localparam int		RESET_CYCLES	= 10;
	// Worst byte at divisor 4, plus issue overhead
	localparam int		BYTE_CYCLES		= 16 * 4 + 8;
	localparam int		SINGLE_BYTES	= 6;
	localparam int		RANDOM_BURSTS	= 3;
	localparam int		BURST_RAND_MAX	= 40;
	localparam int		TOTAL_BYTES		= SINGLE_BYTES + RANDOM_BURSTS * BURST_RAND_MAX +
		`SPI_BURST_MAX;
	localparam int		MARGIN_CYCLES	= 5000;
	localparam longint	WATCHDOG_NS		=
		(longint'(TOTAL_BYTES) * BYTE_CYCLES * 2 + MARGIN_CYCLES) * CLK_PERIOD;
	// Longest stall or poll, one full clamped burst
	localparam int		WAIT_LIMIT		= `SPI_BURST_MAX * BYTE_CYCLES;

	logic					apb;
	logic					reset;
	spi_apb_pkg::apb_req_t	apb_req;
	spi_apb_pkg::apb_rsp_t	apb_rsp;
	logic					spi_sck;
	logic					spi_mosi;
	logic					spi_cs_n;
	logic					spi_miso;
	logic [7:0]				mosi_byte;
	int unsigned			mosi_count;
	int unsigned			reply_count;

	integer			seed;
	int				value_errors;
	int				other_errors;
	// Bytes the device should see on MOSI, in order
	logic [7:0]		mosi_expect [$];
	int unsigned	mosi_seen;
	// Reply index since chip select fell
	int unsigned	dev_k;
	// Divisor as stored by the DUT
	int unsigned	cur_div;
	int unsigned	since_edge;
	int unsigned	rise_in_byte;
	logic			sck_prev;

	spi_apb_host spi_apb_host_inst (
		.apb		(apb),
		.reset		(reset),
		.apb_req	(apb_req),
		.apb_rsp	(apb_rsp),
		.spi_sck	(spi_sck),
		.spi_mosi	(spi_mosi),
		.spi_cs_n	(spi_cs_n),
		.spi_miso	(spi_miso)
	);

	spi_loopback_device spi_loopback_device_inst (
		.spi_sck		(spi_sck),
		.spi_mosi		(spi_mosi),
		.spi_cs_n		(spi_cs_n),
		.spi_miso		(spi_miso),
		.mosi_byte		(mosi_byte),
		.mosi_count		(mosi_count),
		.reply_count	(reply_count)
	);

	initial apb = 1'b0;
	always #(CLK_PERIOD / 2) apb = !apb;

	////////////////////
	// Helpers

	function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
		return lo + ($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// Device reply for byte k after chip select
	function automatic logic [7:0] reply_byte(input int unsigned k);
		return 8'hc3 + k[7:0];
	endfunction

	task automatic compare_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// One APB transfer, sampled just ahead of the completing edge
	task automatic bus_cycle(input logic is_write, input logic [8:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int waits);
		bit done;
		@(negedge apb);
		apb_req.paddr	= addr;
		apb_req.pwrite	= is_write;
		apb_req.pwdata	= wdata;
		apb_req.psel	= 1'b1;
		apb_req.penable	= 1'b0;
		@(negedge apb);
		apb_req.penable	= 1'b1;
		waits	= 0;
		done	= 1'b0;
		rdata	= '0;
		err		= 1'b0;
		while (!done && waits <= WAIT_LIMIT) begin
			#(CLK_PERIOD / 2 - 1);
			if (apb_rsp.pready) begin
				done	= 1'b1;
				rdata	= apb_rsp.prdata;
				err		= apb_rsp.pslverr;
			end else begin
				waits++;
				@(negedge apb);
			end
		end
		if (!done) begin
			other_errors++;
			$display("APB transfer to address %h never completed", addr);
		end
		@(negedge apb);
		apb_req.psel	= 1'b0;
		apb_req.penable	= 1'b0;
	endtask

	task automatic reg_write(input logic [8:0] addr, input logic [31:0] data,
		input logic exp_err, output int waits);
		logic [31:0]	rdata;
		logic			err;
		bus_cycle(1'b1, addr, data, rdata, err, waits);
		compare_word($sformatf("pslverr@%h", addr), exp_err, err);
	endtask

	task automatic reg_check(input logic [8:0] addr, input logic [31:0] exp_data,
		input logic exp_err);
		logic [31:0]	rdata;
		logic			err;
		int				waits;
		bus_cycle(1'b0, addr, '0, rdata, err, waits);
		compare_word($sformatf("pslverr@%h", addr), exp_err, err);
		if (!exp_err)
			compare_word($sformatf("prdata@%h", addr), exp_data, rdata);
	endtask

	task automatic wait_for_idle();
		logic [31:0]	status;
		logic			err;
		int				waits;
		int				polls;
		polls	= 0;
		status	= 32'h1;
		while (status[0] && polls < WAIT_LIMIT) begin
			bus_cycle(1'b0, `SPI_REG_STATUS, '0, status, err, waits);
			polls++;
		end
		if (status[0]) begin
			other_errors++;
			$display("STATUS still busy after %0d polls", polls);
		end
	endtask

	// Zero is stored as 1
	task automatic set_divisor(input int unsigned div);
		int	waits;
		reg_write(`SPI_REG_CLK_DIV, div, 1'b0, waits);
		cur_div	= (div == 0) ? 1 : div;
		reg_check(`SPI_REG_CLK_DIV, cur_div, 1'b0);
	endtask

	task automatic run_single(input logic [7:0] tx);
		int	waits;
		mosi_expect.push_back(tx);
		reg_write(`SPI_REG_DATA, {24'h0, tx}, 1'b0, waits);
		reg_check(`SPI_REG_STATUS, 32'h1, 1'b0);
		wait_for_idle();
		reg_check(`SPI_REG_DATA, {24'h0, reply_byte(dev_k)}, 1'b0);
		dev_k++;
	endtask

	task automatic run_burst(input int unsigned len);
		int unsigned	eff;
		int unsigned	words;
		int unsigned	idx;
		int unsigned	count_before;
		logic [31:0]	expected;
		int				waits;
		eff		= (len > `SPI_BURST_MAX) ? `SPI_BURST_MAX : len;
		words	= (eff + 3) / 4;
		count_before	= mosi_count;
		// Burst clocks out zeros
		for (int i = 0; i < eff; i++)
			mosi_expect.push_back(8'h00);
		reg_write(`SPI_REG_BURST_RDLEN, len, 1'b0, waits);
		if (eff == 0) begin
			reg_check(`SPI_REG_STATUS, 32'h0, 1'b0);
			reg_check(`SPI_REG_STATUS, 32'h0, 1'b0);
			compare_word("mosi_count", count_before, mosi_count);
		end
		wait_for_idle();
		// Little-endian words, missing upper lanes read zero
		for (int w = 0; w < words; w++) begin
			expected	= '0;
			for (int lane = 0; lane < 4; lane++) begin
				idx	= w * 4 + lane;
				if (idx < eff)
					expected[lane * 8 +: 8]	= reply_byte(dev_k + idx);
			end
			reg_check(9'(`SPI_REG_RXBUF + w * 4), expected, 1'b0);
		end
		dev_k	+= eff;
	endtask

	////////////////////
	// Monitors

	// Each byte seen by the device against the queue
	always @(negedge apb) begin
		if (reset) begin
			mosi_seen	= 0;
		end else if (mosi_count != mosi_seen) begin
			mosi_seen	= mosi_count;
			if (mosi_expect.size() == 0) begin
				other_errors++;
				$display("Unexpected byte %h on MOSI", mosi_byte);
			end else begin
				compare_word("spi_mosi byte", mosi_expect.pop_front(), mosi_byte);
			end
		end
	end

	// SCK half-period in apb cycles
	always @(negedge apb) begin
		if (reset) begin
			since_edge		= 1;
			rise_in_byte	= 0;
			sck_prev		= 1'b0;
		end else if (spi_sck !== sck_prev) begin
			// First rise of a byte follows the issue delay instead
			if (!spi_sck || rise_in_byte != 0)
				compare_word("spi_sck half-period", cur_div, since_edge);
			if (spi_sck)
				rise_in_byte	= (rise_in_byte + 1) % 8;
			since_edge	= 1;
			sck_prev	= spi_sck;
		end else begin
			since_edge++;
		end
	end

	assert property (@(posedge apb) disable iff (reset)
		apb_rsp.pready |-> apb_req.psel && apb_req.penable)
	else begin
		other_errors++;
		$display("pready was raised outside an APB access phase");
	end

	// Device samples a settled bit while SCK is high
	assert property (@(posedge apb) disable iff (reset)
		$past(spi_sck) && spi_sck |-> $stable(spi_mosi))
	else begin
		other_errors++;
		$display("MOSI changed while SCK was high");
	end

	// Chip select moves only by a CS_N write
	assert property (@(posedge apb) disable iff (reset)
		$changed(spi_cs_n) |-> $past(apb_req.psel && apb_req.penable &&
			apb_req.pwrite && apb_req.paddr == `SPI_REG_CS_N))
	else begin
		other_errors++;
		$display("spi_cs_n changed without a CS_N write");
	end

	////////////////////
	// Stimulus

	initial begin
		logic [7:0]		first_byte;
		logic [7:0]		second_byte;
		int unsigned	k_before;
		int				waits;
		seed			= 32'h6deee3f1;
		value_errors	= 0;
		other_errors	= 0;
		dev_k			= 0;
		cur_div			= `SPI_CLKDIV_RESET;
		apb_req			= '0;
		reset			= 1'b1;
		repeat (RESET_CYCLES) @(posedge apb);
		@(negedge apb);
		reset			= 1'b0;

		// Reset values
		compare_word("spi_cs_n", 32'h1, spi_cs_n);
		compare_word("spi_sck", 32'h0, spi_sck);
		reg_check(`SPI_REG_CLK_DIV, `SPI_CLKDIV_RESET, 1'b0);
		reg_check(`SPI_REG_CS_N, 32'h1, 1'b0);
		reg_check(`SPI_REG_STATUS, 32'h0, 1'b0);
		reg_check(`SPI_REG_STATUS_2, 32'h0, 1'b0);
		reg_check(`SPI_REG_QUAD_CAP, 32'h0, 1'b0);

		// Register rules
		set_divisor(rand_range(1, 4));
		set_divisor(0);
		reg_write(`SPI_REG_CS_N, 32'h0, 1'b0, waits);
		compare_word("spi_cs_n", 32'h0, spi_cs_n);
		reg_check(`SPI_REG_CS_N, 32'h0, 1'b0);
		reg_write(`SPI_REG_CS_N, 32'h1, 1'b0, waits);
		compare_word("spi_cs_n", 32'h1, spi_cs_n);
		reg_write(`SPI_REG_STATUS, 32'h1, 1'b1, waits);
		reg_check(9'h0e0, 32'h0, 1'b1);
		reg_write(9'h0e0, 32'h5a, 1'b1, waits);

		// Single bytes, device count restarts here
		reg_write(`SPI_REG_CS_N, 32'h0, 1'b0, waits);
		dev_k	= 0;
		repeat (SINGLE_BYTES - 2) begin
			set_divisor(rand_range(1, 4));
			run_single(8'($random(seed)));
		end

		// Second DATA write stalls until the first byte is back
		first_byte	= 8'($random(seed));
		second_byte	= 8'($random(seed));
		mosi_expect.push_back(first_byte);
		mosi_expect.push_back(second_byte);
		k_before	= reply_count;
		reg_write(`SPI_REG_DATA, {24'h0, first_byte}, 1'b0, waits);
		reg_write(`SPI_REG_DATA, {24'h0, second_byte}, 1'b0, waits);
		if (waits == 0) begin
			other_errors++;
			$display("Second DATA write completed without a wait state");
		end
		compare_word("reply_count", k_before + 1, reply_count);
		wait_for_idle();
		reg_check(`SPI_REG_DATA, {24'h0, reply_byte(dev_k + 1)}, 1'b0);
		dev_k	+= 2;

		// Bursts, random, empty and clamped
		repeat (RANDOM_BURSTS) begin
			set_divisor(rand_range(1, 4));
			run_burst(rand_range(1, BURST_RAND_MAX));
		end
		run_burst(0);
		set_divisor(rand_range(1, 4));
		run_burst(300);

		if (mosi_expect.size() != 0) begin
			other_errors++;
			$display("%0d expected MOSI bytes never appeared", mosi_expect.size());
		end

		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: spi_apb.f
+incdir+verilog
verilog/spi_apb_pkg.sv
verilog/spi_sck_timer.sv
verilog/spi_shifter.sv
verilog/spi_burst_sequencer.sv
verilog/spi_burst_buffer.sv
verilog/spi_apb_regs.sv
verilog/spi_apb_host.sv
sim/spi_loopback_device.sv
sim/spi_apb_host_tb.sv

// File: Bender.yml
package:
  name: spi_apb

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/spi_apb_pkg.sv
      - verilog/spi_sck_timer.sv
      - verilog/spi_shifter.sv
      - verilog/spi_burst_sequencer.sv
      - verilog/spi_burst_buffer.sv
      - verilog/spi_apb_regs.sv
      - verilog/spi_apb_host.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/spi_loopback_device.sv
      - sim/spi_apb_host_tb.sv
